// ==== Makefile ====
# Verilator build and run of the thread controller testbench

VERILATOR ?= verilator
TOP       ?= thread_ctrl_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= Verification passed

.PHONY: sim clean

# Build, run, and pass only if the run prints the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/thread_ctrl_props.sv ====
// Concurrent assertions for the thread controller
// Command status timing, table consistency, scheduler hold

`timescale 1ns/1ps

module thread_ctrl_props (
    input logic                   clk,
    input logic                   rst_n,
    input trd_cmd_pkg::trd_cmd_t  cmd,
    input trd_cmd_pkg::trd_stat_t stat,
    input trd_cfg_pkg::trd_mask_t valid_trd,
    input trd_cfg_pkg::trd_mask_t run_trd,
    input trd_cfg_pkg::trd_id_t   cur_trd,
    input logic                   stall,
    input logic                   atomic
);

    done_after_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd.op != trd_cmd_pkg::OP_NONE) |=> stat.done)
        else $error("stat.done missing one cycle after a command");

    // No stray status after an idle cycle
    idle_no_done: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd.op == trd_cmd_pkg::OP_NONE) |=> !stat.done)
        else $error("stat.done set without a command");

    run_in_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (run_trd & ~valid_trd) == '0)
        else $error("running thread is not valid");

    root_valid: assert property (@(posedge clk) disable iff (!rst_n)
        valid_trd[trd_cfg_pkg::ROOT_TRD])
        else $error("thread 0 lost its valid bit");

    hold_cur: assert property (@(posedge clk) disable iff (!rst_n)
        (stall || atomic) |=> (cur_trd == $past(cur_trd)))
        else $error("cur_trd moved during stall or atomic");

endmodule

bind thread_ctrl thread_ctrl_props thread_ctrl_props_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .stat      (stat),
    .valid_trd (valid_trd),
    .run_trd   (run_trd),
    .cur_trd   (cur_trd),
    .stall     (stall),
    .atomic    (atomic)
);

// ==== dv/thread_ctrl_tb.sv ====
// Testbench for the thread controller
// Clock, reset, directed and random stimulus, reference model
// Compare tasks, cycle limit and run summary

`timescale 1ns/1ps

module thread_ctrl_tb;

    localparam trd_cfg_pkg::pc_t    RESET_PC = 32'h0000_1000;
    localparam int                  NUM_TRD  = trd_cfg_pkg::NUM_TRD;
    localparam trd_cmd_pkg::pc_wb_t NO_WB    = '0;

    localparam int RST_CYC    = 4;
    localparam int FILL_CYC   = NUM_TRD + 2;
    localparam int PERM_CYC   = 6 * NUM_TRD + 4;
    localparam int SINGLE_CYC = 16;
    localparam int RR_CYC     = 80 + NUM_TRD;
    localparam int RAND_CYC   = 2000;
    localparam int MAX_CYC    = RST_CYC + FILL_CYC + PERM_CYC + SINGLE_CYC + RR_CYC
                                + RAND_CYC + 200;

    logic                   clk;
    logic                   rst_n;
    trd_cmd_pkg::trd_cmd_t  cmd;
    trd_cmd_pkg::pc_wb_t    pc_wb;
    logic                   stall;
    logic                   atomic;
    trd_cmd_pkg::trd_stat_t stat;
    trd_cfg_pkg::trd_id_t   cur_trd;
    trd_cfg_pkg::pc_t       cur_pc;
    trd_cfg_pkg::trd_mask_t valid_trd;
    trd_cfg_pkg::trd_mask_t run_trd;
    logic                   trd_full;

    // Reference model state
    trd_cfg_pkg::trd_mask_t m_valid;
    trd_cfg_pkg::trd_mask_t m_run;
    trd_cfg_pkg::trd_id_t   m_par [NUM_TRD];
    trd_cfg_pkg::pc_t       m_pc  [NUM_TRD];
    trd_cfg_pkg::trd_id_t   m_cur;
    trd_cmd_pkg::trd_stat_t m_stat;

    // Inputs the DUT takes at the coming edge
    trd_cmd_pkg::trd_cmd_t  p_cmd;
    trd_cmd_pkg::pc_wb_t    p_wb;
    logic                   p_stall;
    logic                   p_atomic;

    integer seed;
    int     err_cnt = 0;
    int     chk_cnt = 0;
    int     test_cnt = 0;
    int     test_err0;
    int     test_chk0;
    int     cyc_cnt = 0;

    thread_ctrl #(
        .RESET_PC (RESET_PC)
    ) thread_ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .pc_wb     (pc_wb),
        .stall     (stall),
        .atomic    (atomic),
        .stat      (stat),
        .cur_trd   (cur_trd),
        .cur_pc    (cur_pc),
        .valid_trd (valid_trd),
        .run_trd   (run_trd),
        .trd_full  (trd_full)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc_cnt = cyc_cnt + 1;
        if (cyc_cnt > MAX_CYC) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYC);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic compare_stat(input string name, input trd_cmd_pkg::trd_stat_t got,
                                input trd_cmd_pkg::trd_stat_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_trd(input string name, input trd_cfg_pkg::trd_id_t got,
                               input trd_cfg_pkg::trd_id_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compare_pc(input string name, input trd_cfg_pkg::pc_t got,
                              input trd_cfg_pkg::pc_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_mask(input string name, input trd_cfg_pkg::trd_mask_t got,
                                input trd_cfg_pkg::trd_mask_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    function automatic int roll(input int n);
        return {$random(seed)} % n;
    endfunction

    function automatic trd_cfg_pkg::trd_id_t any_trd();
        return trd_cfg_pkg::trd_id_t'(roll(NUM_TRD));
    endfunction

    function automatic trd_cfg_pkg::pc_t any_pc();
        return trd_cfg_pkg::pc_t'($random(seed));
    endfunction

    // Random live thread out of a set that always holds thread 0
    function automatic trd_cfg_pkg::trd_id_t live_trd();
        trd_cfg_pkg::trd_id_t start;
        trd_cfg_pkg::trd_id_t idx;
        trd_cfg_pkg::trd_id_t pick;
        logic                 found;
        start = any_trd();
        pick  = '0;
        found = 1'b0;
        for (int k = 0; k < NUM_TRD; k++) begin
            idx = start + trd_cfg_pkg::trd_id_t'(k);
            if (!found && m_valid[idx]) begin
                pick  = idx;
                found = 1'b1;
            end
        end
        return pick;
    endfunction

    function automatic trd_cfg_pkg::trd_id_t first_free();
        trd_cfg_pkg::trd_id_t idx;
        trd_cfg_pkg::trd_id_t pick;
        logic                 found;
        pick  = '0;
        found = 1'b0;
        for (int i = 0; i < NUM_TRD; i++) begin
            idx = trd_cfg_pkg::trd_id_t'(i);
            if (!found && !m_valid[idx]) begin
                pick  = idx;
                found = 1'b1;
            end
        end
        return pick;
    endfunction

    // A thread that is neither the target nor its parent
    function automatic trd_cfg_pkg::trd_id_t bystander(input trd_cfg_pkg::trd_id_t t,
                                                       input trd_cfg_pkg::trd_id_t p);
        trd_cfg_pkg::trd_id_t idx;
        idx = '0;
        while (idx == t || idx == p) begin
            idx = idx + trd_cfg_pkg::trd_id_t'(1);
        end
        return idx;
    endfunction

    function automatic logic allowed(input trd_cfg_pkg::trd_id_t act,
                                     input trd_cfg_pkg::trd_id_t obj);
        return m_valid[obj] && (obj != 0) && (act == obj || act == m_par[obj]);
    endfunction

    function automatic trd_cmd_pkg::trd_cmd_t make_cmd(input trd_cmd_pkg::trd_op_e op,
                                                       input trd_cfg_pkg::trd_id_t act,
                                                       input trd_cfg_pkg::trd_id_t obj,
                                                       input trd_cfg_pkg::pc_t pc);
        trd_cmd_pkg::trd_cmd_t c;
        c.op      = op;
        c.act_trd = act;
        c.obj_trd = obj;
        c.init_pc = pc;
        return c;
    endfunction

    task automatic reset_model();
        m_valid = trd_cfg_pkg::trd_mask_t'(1);  // Thread 0 only
        m_run   = trd_cfg_pkg::trd_mask_t'(1);
        m_cur   = '0;
        m_stat  = '0;
        for (int i = 0; i < NUM_TRD; i++) begin
            m_par[i] = '0;
            m_pc[i]  = RESET_PC;
        end
        p_cmd    = '0;
        p_wb     = NO_WB;
        p_stall  = 1'b0;
        p_atomic = 1'b0;
    endtask

    // One clock edge of the reference model
    task automatic apply_edge(input trd_cmd_pkg::trd_cmd_t c, input trd_cmd_pkg::pc_wb_t w,
                              input logic s, input logic a);
        trd_cfg_pkg::trd_id_t nxt;
        trd_cfg_pkg::trd_id_t cand;
        trd_cfg_pkg::trd_id_t slot;
        logic                 found;
        nxt   = m_cur;
        found = 1'b0;
        if (!(s || a)) begin
            for (int k = 1; k < NUM_TRD; k++) begin
                cand = trd_cfg_pkg::trd_id_t'((int'(m_cur) + k) % NUM_TRD);
                if (!found && m_run[cand]) begin
                    nxt   = cand;
                    found = 1'b1;
                end
            end
        end
        if (w.wr) m_pc[w.trd] = w.pc;
        m_stat      = '0;
        m_stat.done = (c.op != trd_cmd_pkg::OP_NONE);
        case (c.op)
            trd_cmd_pkg::OP_INIT: begin
                if (&m_valid) begin
                    m_stat.overflow = 1'b1;
                end else begin
                    slot           = first_free();
                    m_valid[slot]  = 1'b1;
                    m_run[slot]    = 1'b1;
                    m_par[slot]    = c.act_trd;
                    m_pc[slot]     = c.init_pc;  // Beats a write-back to the same thread
                    m_stat.new_trd = slot;
                end
            end
            trd_cmd_pkg::OP_KILL: begin
                if (allowed(c.act_trd, c.obj_trd)) begin
                    m_valid[c.obj_trd] = 1'b0;
                    m_run[c.obj_trd]   = 1'b0;
                end else begin
                    m_stat.invalid_op = 1'b1;
                end
            end
            trd_cmd_pkg::OP_SLEEP: begin
                if (allowed(c.act_trd, c.obj_trd)) m_run[c.obj_trd] = 1'b0;
                else m_stat.invalid_op = 1'b1;
            end
            trd_cmd_pkg::OP_WAKE: begin
                if (allowed(c.act_trd, c.obj_trd)) m_run[c.obj_trd] = 1'b1;
                else m_stat.invalid_op = 1'b1;
            end
            default: begin
            end
        endcase
        m_cur = nxt;
    endtask

    task automatic check_outputs();
        compare_stat("stat", stat, m_stat);
        compare_trd("cur_trd", cur_trd, m_cur);
        compare_pc("cur_pc", cur_pc, m_pc[m_cur]);
        compare_mask("valid_trd", valid_trd, m_valid);
        compare_mask("run_trd", run_trd, m_run);
        compare_bit("trd_full", trd_full, &m_valid);
    endtask

    // Model the edge, drive the next inputs and check at the falling edge
    task automatic step(input trd_cmd_pkg::trd_cmd_t c, input trd_cmd_pkg::pc_wb_t w,
                        input logic s, input logic a);
        @(posedge clk);
        apply_edge(p_cmd, p_wb, p_stall, p_atomic);
        cmd      <= c;
        pc_wb    <= w;
        stall    <= s;
        atomic   <= a;
        p_cmd    = c;
        p_wb     = w;
        p_stall  = s;
        p_atomic = a;
        @(negedge clk);
        check_outputs();
    endtask

    task automatic issue(input trd_cmd_pkg::trd_op_e op, input trd_cfg_pkg::trd_id_t act,
                         input trd_cfg_pkg::trd_id_t obj);
        step(make_cmd(op, act, obj, '0), NO_WB, 1'b0, 1'b0);
    endtask

    task automatic idle(input int n);
        repeat (n) step('0, NO_WB, 1'b0, 1'b0);
    endtask

    task automatic begin_test();
        test_err0 = err_cnt;
        test_chk0 = chk_cnt;
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (err_cnt == test_err0) begin
            $display("test %-16s ok, %0d checks", name, chk_cnt - test_chk0);
        end else begin
            $display("test %-16s FAILED, %0d of %0d checks wrong", name,
                     err_cnt - test_err0, chk_cnt - test_chk0);
        end
    endtask

    task automatic fill_table();
        begin_test();
        for (int i = 1; i <= NUM_TRD; i++) begin     // Last create overflows
            step(make_cmd(trd_cmd_pkg::OP_INIT, live_trd(), '0, any_pc()), NO_WB,
                 1'b0, 1'b0);
        end
        idle(1);
        end_test("create_fill");
    endtask

    task automatic check_permissions();
        trd_cfg_pkg::trd_id_t t;
        trd_cfg_pkg::trd_id_t p;
        begin_test();
        for (int i = 1; i < NUM_TRD; i++) begin
            t = trd_cfg_pkg::trd_id_t'(i);
            p = m_par[t];
            issue(trd_cmd_pkg::OP_SLEEP, bystander(t, p), t);
            issue(trd_cmd_pkg::OP_SLEEP, t, t);
            issue(trd_cmd_pkg::OP_WAKE, p, t);
            issue(trd_cmd_pkg::OP_WAKE, bystander(t, p), t);
        end
        issue(trd_cmd_pkg::OP_KILL, '0, '0);        // Root cannot be killed
        issue(trd_cmd_pkg::OP_SLEEP, '0, '0);
        // Children first so every parent is still alive
        for (int i = NUM_TRD - 1; i >= 1; i--) begin
            t = trd_cfg_pkg::trd_id_t'(i);
            issue(trd_cmd_pkg::OP_KILL, (i % 2 == 1) ? t : m_par[t], t);
        end
        issue(trd_cmd_pkg::OP_KILL, '0, 3'd3);       // Target already dead
        issue(trd_cmd_pkg::OP_WAKE, 3'd3, 3'd3);
        idle(1);
        end_test("permission");
    endtask

    task automatic hold_single();
        begin_test();
        idle(SINGLE_CYC);
        end_test("single_running");
    endtask

    task automatic round_robin();
        begin_test();
        for (int i = 0; i < 5; i++) begin
            step(make_cmd(trd_cmd_pkg::OP_INIT, '0, '0, any_pc()), NO_WB, 1'b0, 1'b0);
        end
        issue(trd_cmd_pkg::OP_SLEEP, 3'd3, 3'd3);
        for (int i = 0; i < 80; i++) begin
            step('0, NO_WB, roll(4) == 0, roll(4) == 0);
        end
        idle(1);
        end_test("round_robin");
    endtask

    task automatic random_mix();
        trd_cmd_pkg::trd_cmd_t c;
        trd_cmd_pkg::pc_wb_t   w;
        logic                  drain;
        int                    r;
        begin_test();
        for (int i = 0; i < RAND_CYC; i++) begin
            drain     = ((i / 128) % 2) == 1;     // Alternate filling and draining
            r         = roll(100);
            c.obj_trd = any_trd();
            c.init_pc = any_pc();
            case (roll(4))
                0, 1:    c.act_trd = m_par[c.obj_trd];
                2:       c.act_trd = c.obj_trd;
                default: c.act_trd = any_trd();
            endcase
            if (r < (drain ? 10 : 45))      c.op = trd_cmd_pkg::OP_INIT;
            else if (r < (drain ? 50 : 55)) c.op = trd_cmd_pkg::OP_KILL;
            else if (r < (drain ? 65 : 70)) c.op = trd_cmd_pkg::OP_SLEEP;
            else if (r < (drain ? 80 : 85)) c.op = trd_cmd_pkg::OP_WAKE;
            else                            c.op = trd_cmd_pkg::OP_NONE;
            w.wr  = roll(5) < 2;
            w.trd = any_trd();
            w.pc  = any_pc();
            if (c.op == trd_cmd_pkg::OP_INIT && roll(3) == 0) begin
                w.wr  = 1'b1;
                w.trd = first_free();               // Aim at the thread being created
            end
            step(c, w, roll(5) == 0, roll(8) == 0);
        end
        idle(1);
        end_test("random_mix");
    endtask

    initial begin
        seed   = 32'he9f15398;
        rst_n  = 1'b0;
        cmd    = '0;
        pc_wb  = NO_WB;
        stall  = 1'b0;
        atomic = 1'b0;
        reset_model();
        repeat (RST_CYC) @(posedge clk);
        rst_n <= 1'b1;
        begin_test();
        @(negedge clk);
        check_outputs();
        compare_pc("cur_pc", cur_pc, RESET_PC);
        end_test("reset");
        fill_table();
        check_permissions();
        hold_single();
        round_robin();
        random_mix();
        $display("Summary: %0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/trd_cfg_pkg.sv
rtl/trd_cmd_pkg.sv
rtl/trd_cmd_decode.sv
rtl/thread_table.sv
rtl/thread_sched.sv
rtl/thread_ctrl.sv
dv/thread_ctrl_props.sv
dv/thread_ctrl_tb.sv

// ==== rtl/thread_ctrl.sv ====
// Thread controller top level for the fetch stage
// Command decode, thread table and round-robin scheduler

`timescale 1ns/1ps

module thread_ctrl #(
    parameter trd_cfg_pkg::pc_t RESET_PC = '0
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  trd_cmd_pkg::trd_cmd_t  cmd,         // One command per cycle
    input  trd_cmd_pkg::pc_wb_t    pc_wb,       // Next pc of one thread
    input  logic                   stall,
    input  logic                   atomic,
    output trd_cmd_pkg::trd_stat_t stat,
    output trd_cfg_pkg::trd_id_t   cur_trd,
    output trd_cfg_pkg::pc_t       cur_pc,
    output trd_cfg_pkg::trd_mask_t valid_trd,
    output trd_cfg_pkg::trd_mask_t run_trd,
    output logic                   trd_full
);

    trd_cmd_pkg::trd_upd_t                              upd;
    trd_cfg_pkg::trd_id_t [trd_cfg_pkg::NUM_TRD-1:0]    par_trd;
    trd_cfg_pkg::pc_t     [trd_cfg_pkg::NUM_TRD-1:0]    trd_pc;

    trd_cmd_decode trd_cmd_decode_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .valid_trd (valid_trd),
        .run_trd   (run_trd),
        .par_trd   (par_trd),
        .upd       (upd),
        .stat      (stat),
        .trd_full  (trd_full)
    );

    thread_table #(
        .RESET_PC (RESET_PC)
    ) thread_table_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .upd       (upd),
        .pc_wb     (pc_wb),
        .valid_trd (valid_trd),
        .run_trd   (run_trd),
        .par_trd   (par_trd),
        .trd_pc    (trd_pc)
    );

    thread_sched thread_sched_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .atomic    (atomic),
        .run_trd   (run_trd),
        .trd_pc    (trd_pc),
        .cur_trd   (cur_trd),
        .cur_pc    (cur_pc)
    );

endmodule

// ==== rtl/thread_sched.sv ====
// Round-robin thread scheduler
// Current thread pointer over the running set, current pc select

`timescale 1ns/1ps

module thread_sched (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            stall,
    input  logic                                            atomic,
    input  trd_cfg_pkg::trd_mask_t                          run_trd,
    input  trd_cfg_pkg::pc_t     [trd_cfg_pkg::NUM_TRD-1:0] trd_pc,
    output trd_cfg_pkg::trd_id_t                            cur_trd,
    output trd_cfg_pkg::pc_t                                cur_pc
);

    trd_cfg_pkg::trd_id_t nxt_trd;
    logic                 hold;                 // Keep the current thread

    // First running thread after cur in circular order, cur itself if none
    function automatic trd_cfg_pkg::trd_id_t next_running(
        input trd_cfg_pkg::trd_id_t   cur,
        input trd_cfg_pkg::trd_mask_t run
    );
        trd_cfg_pkg::trd_id_t idx;
        trd_cfg_pkg::trd_id_t pick;
        pick = cur;
        // Farthest candidate first so the nearest one is kept
        for (int i = trd_cfg_pkg::NUM_TRD - 1; i >= 1; i--) begin
            idx = cur + trd_cfg_pkg::trd_id_t'(i);  // Wraps at NUM_TRD
            if (run[idx]) begin
                pick = idx;
            end
        end
        return pick;
    endfunction

    assign hold    = stall | atomic;
    assign nxt_trd = hold ? cur_trd : next_running(cur_trd, run_trd);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_trd <= trd_cfg_pkg::ROOT_TRD;
        end else begin
            cur_trd <= nxt_trd;
        end
    end

    assign cur_pc = trd_pc[cur_trd];            // Follows table writes directly

endmodule

// ==== rtl/thread_table.sv ====
// Per-thread state table
// Valid and running masks, parent index and program counter of each thread
// One command update and one pc write-back per cycle

`timescale 1ns/1ps

module thread_table #(
    parameter trd_cfg_pkg::pc_t RESET_PC = '0
) (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  trd_cmd_pkg::trd_upd_t                           upd,
    input  trd_cmd_pkg::pc_wb_t                             pc_wb,
    output trd_cfg_pkg::trd_mask_t                          valid_trd,
    output trd_cfg_pkg::trd_mask_t                          run_trd,
    output trd_cfg_pkg::trd_id_t [trd_cfg_pkg::NUM_TRD-1:0] par_trd,
    output trd_cfg_pkg::pc_t     [trd_cfg_pkg::NUM_TRD-1:0] trd_pc
);

    logic create;                               // Approved create this cycle

    assign create = (upd.op == trd_cmd_pkg::OP_INIT);

    // Valid and running flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_trd <= trd_cfg_pkg::RESET_MASK;
            run_trd   <= trd_cfg_pkg::RESET_MASK;
        end else begin
            case (upd.op)
                trd_cmd_pkg::OP_INIT: begin
                    valid_trd[upd.trd] <= 1'b1;
                    run_trd[upd.trd]   <= 1'b1;  // New threads start running
                end
                trd_cmd_pkg::OP_KILL: begin
                    valid_trd[upd.trd] <= 1'b0;
                    run_trd[upd.trd]   <= 1'b0;
                end
                trd_cmd_pkg::OP_SLEEP: begin
                    run_trd[upd.trd]   <= 1'b0;
                end
                trd_cmd_pkg::OP_WAKE: begin
                    run_trd[upd.trd]   <= 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    // Parent is only looked at while the thread is valid
    always_ff @(posedge clk) begin
        if (create) begin
            par_trd[upd.trd] <= upd.parent;
        end
    end

    // Program counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < trd_cfg_pkg::NUM_TRD; i++) begin
                trd_pc[i] <= RESET_PC;
            end
        end else begin
            if (pc_wb.wr) begin
                trd_pc[pc_wb.trd] <= pc_wb.pc;
            end
            if (create) begin
                trd_pc[upd.trd] <= upd.pc;       // Later write wins over write-back
            end
        end
    end

endmodule

// ==== rtl/trd_cfg_pkg.sv ====
// Thread controller sizing constants
// Thread index, thread mask and program counter types
// Reset values for the thread table and scheduler

package trd_cfg_pkg;

    parameter int NUM_TRD = 8;                  // Hardware threads
    parameter int TRD_W   = 3;                  // Thread index width
    parameter int PC_W    = 32;                 // Program counter width

    typedef logic [TRD_W-1:0]   trd_id_t;       // Thread index
    typedef logic [NUM_TRD-1:0] trd_mask_t;     // One bit per thread
    typedef logic [PC_W-1:0]    pc_t;           // Program counter

    // Thread 0 is the root thread, alive out of reset and never killed
    parameter trd_id_t ROOT_TRD = trd_id_t'(0);

    // Valid and running set after reset, root thread only
    parameter trd_mask_t RESET_MASK = trd_mask_t'(1) << ROOT_TRD;

endpackage

// ==== rtl/trd_cmd_decode.sv ====
// Thread command decode
// Free thread search, permission and overflow checks
// Table update generation and registered command status

`timescale 1ns/1ps

module trd_cmd_decode (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  trd_cmd_pkg::trd_cmd_t                       cmd,
    input  trd_cfg_pkg::trd_mask_t                      valid_trd,
    input  trd_cfg_pkg::trd_mask_t                      run_trd,
    input  trd_cfg_pkg::trd_id_t [trd_cfg_pkg::NUM_TRD-1:0] par_trd,
    output trd_cmd_pkg::trd_upd_t                       upd,
    output trd_cmd_pkg::trd_stat_t                      stat,
    output logic                                        trd_full
);

    trd_cfg_pkg::trd_id_t   free_trd;           // Lowest invalid thread
    logic                   obj_ok;             // Kill, sleep or wake is allowed
    trd_cmd_pkg::trd_stat_t nxt_stat;

    assign trd_full = &valid_trd;

    // Scan downward so the lowest free index is the last one kept
    always_comb begin
        free_trd = trd_cfg_pkg::ROOT_TRD;
        for (int i = trd_cfg_pkg::NUM_TRD - 1; i >= 0; i--) begin
            if (!valid_trd[i]) begin
                free_trd = trd_cfg_pkg::trd_id_t'(i);
            end
        end
    end

    // Only the target itself or its parent may act on a live non-root thread
    assign obj_ok = valid_trd[cmd.obj_trd] &&
                    (cmd.obj_trd != trd_cfg_pkg::ROOT_TRD) &&
                    ((cmd.act_trd == cmd.obj_trd) ||
                     (cmd.act_trd == par_trd[cmd.obj_trd]));

    always_comb begin
        upd        = '0;
        upd.op     = trd_cmd_pkg::OP_NONE;
        upd.trd    = cmd.obj_trd;
        upd.parent = cmd.act_trd;               // Creator becomes the parent
        upd.pc     = cmd.init_pc;

        nxt_stat      = '0;
        nxt_stat.done = (cmd.op != trd_cmd_pkg::OP_NONE);

        case (cmd.op)
            trd_cmd_pkg::OP_NONE: begin
            end
            trd_cmd_pkg::OP_INIT: begin
                if (trd_full) begin
                    nxt_stat.overflow = 1'b1;
                end else begin
                    upd.op           = trd_cmd_pkg::OP_INIT;
                    upd.trd          = free_trd;
                    nxt_stat.new_trd = free_trd;
                end
            end
            trd_cmd_pkg::OP_KILL: begin
                if (obj_ok) upd.op = trd_cmd_pkg::OP_KILL;
                else        nxt_stat.invalid_op = 1'b1;
            end
            // Sleep or wake of a thread already in that state is legal
            // but leaves the table untouched
            trd_cmd_pkg::OP_SLEEP: begin
                if (!obj_ok)                    nxt_stat.invalid_op = 1'b1;
                else if (run_trd[cmd.obj_trd])  upd.op = trd_cmd_pkg::OP_SLEEP;
            end
            trd_cmd_pkg::OP_WAKE: begin
                if (!obj_ok)                    nxt_stat.invalid_op = 1'b1;
                else if (!run_trd[cmd.obj_trd]) upd.op = trd_cmd_pkg::OP_WAKE;
            end
            default: begin
                nxt_stat.invalid_op = 1'b1;     // Unknown opcode
            end
        endcase
    end

    // Status describes the command of the previous cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stat <= '0;
        end else begin
            stat <= nxt_stat;
        end
    end

endmodule

// ==== rtl/trd_cmd_pkg.sv ====
// Thread command opcodes
// Command, table update, status and pc write-back structs

package trd_cmd_pkg;

    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,                        // No command this cycle
        OP_INIT  = 3'd1,                        // Create a thread
        OP_KILL  = 3'd2,                        // Kill a thread
        OP_SLEEP = 3'd3,                        // Stop scheduling a thread
        OP_WAKE  = 3'd4                         // Resume a sleeping thread
    } trd_op_e;

    // Command from the fetch logic
    typedef struct packed {
        trd_op_e              op;
        trd_cfg_pkg::trd_id_t act_trd;          // Issuing thread
        trd_cfg_pkg::trd_id_t obj_trd;          // Target, unused by create
        trd_cfg_pkg::pc_t     init_pc;          // Start pc of a new thread
    } trd_cmd_t;

    // Approved change to the thread table
    typedef struct packed {
        trd_op_e              op;               // OP_NONE leaves the table alone
        trd_cfg_pkg::trd_id_t trd;
        trd_cfg_pkg::trd_id_t parent;
        trd_cfg_pkg::pc_t     pc;
    } trd_upd_t;

    // Registered command result
    typedef struct packed {
        logic                 done;             // A command was taken last cycle
        trd_cfg_pkg::trd_id_t new_trd;          // Thread given to a create
        logic                 invalid_op;       // Refused kill, sleep or wake
        logic                 overflow;         // Create with no free thread
    } trd_stat_t;

    // Program counter write-back
    typedef struct packed {
        logic                 wr;
        trd_cfg_pkg::trd_id_t trd;
        trd_cfg_pkg::pc_t     pc;
    } pc_wb_t;

endpackage
